// File: video_timing_pkg.sv
//--------------------------------------------------------------------
// display timing defaults and pixel types shared by the video side
//--------------------------------------------------------------------
`default_nettype none

package video_timing_pkg;

   //-----------------------------------------------------------------
   // 640x480 timing at 36 MHz, 832 clocks per line, 509 lines
   //-----------------------------------------------------------------
   localparam int ACTIVE_H = 640;   // visible pixels per line
   localparam int ACTIVE_V = 480;   // visible lines per frame
   localparam int H_FP     = 32;    // horizontal front porch
   localparam int H_PULSE  = 48;    // hsync low time
   localparam int H_BP     = 112;   // horizontal back porch
   localparam int V_FP     = 1;     // vertical front porch, in lines
   localparam int V_PULSE  = 3;     // vsync low time, in lines
   localparam int V_BP     = 25;    // vertical back porch, in lines

   // pixel position or raw counter value, 832 fits in 10 bits
   typedef logic [9:0] coord_t;

   // one bit per gun, red in the msb
   typedef struct packed
   {
      logic red;
      logic green;
      logic blue;
   } rgb_t;

   // everything the monitor side sees, all fields registered
   typedef struct packed
   {
      logic   hsync;    // active low
      logic   vsync;    // active low
      rgb_t   colour;   // 0 outside the active window
      coord_t x;        // active column, 0 in blanking
      coord_t y;        // active line, 0 in blanking
   } vga_out_t;

endpackage

`default_nettype wire

// File: tile_cmd_pkg.sv
//--------------------------------------------------------------------
// host command formats, tile grid geometry and store request type
//--------------------------------------------------------------------
`default_nettype none

package tile_cmd_pkg;

   // grid geometry
   localparam int TILE_SHIFT = 5;                      // 32x32 tiles
   localparam int GRID_COLS  = 20;                     // 640 / 32
   localparam int GRID_ROWS  = 15;                     // 480 / 32
   localparam int TILE_COUNT = GRID_COLS * GRID_ROWS;  // 300 entries

   typedef logic [8:0] tile_addr_t;   // row * 20 + col

   typedef enum logic
   {
      OP_TILE = 1'b0,   // write one tile
      OP_BG   = 1'b1    // set background colour
   } cmd_op_e;

   //-----------------------------------------------------------------
   // the two views of one 16 bit command word, opcode in the msb
   //-----------------------------------------------------------------
   typedef struct packed
   {
      cmd_op_e              op;
      logic [4:0]           col;      // 0..19 valid
      logic [3:0]           row;      // 0..14 valid
      video_timing_pkg::rgb_t colour;
      logic [2:0]           spare;
   } tile_write_t;

   typedef struct packed
   {
      cmd_op_e              op;
      logic [11:0]          spare;
      video_timing_pkg::rgb_t colour;
   } bg_set_t;

   typedef union packed
   {
      tile_write_t tile;
      bg_set_t     bg;
   } cmd_u;

   // one cycle write strobe from decoder to store
   typedef struct packed
   {
      logic                 valid;
      logic                 is_bg;    // background reg instead of map
      tile_addr_t           addr;
      video_timing_pkg::rgb_t colour;
   } store_req_t;

endpackage

`default_nettype wire

// File: cmd_decoder.sv
//--------------------------------------------------------------------
// four-phase req/ack slave, turns one host command into a store write
//--------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module cmd_decoder
(
   input  wire                      clk_36MHz,
   input  wire                      arst_n,
   input  wire                      req,
   input  wire tile_cmd_pkg::cmd_u  cmd,
   output logic                     ack,
   output tile_cmd_pkg::store_req_t store
);
   import tile_cmd_pkg::*;

   typedef enum logic [1:0]
   {
      S_IDLE,    // waiting for req
      S_ISSUE,   // command held, strobe goes out next
      S_ACKD     // ack up, waiting for req to drop
   } state_e;

   state_e     state;
   cmd_u       cmd_q;      // captured command word
   logic       in_range;   // tile coordinates inside the grid
   store_req_t next_req;

   // capture register, only loaded on accept
   always_ff @(posedge clk_36MHz)
   begin
      if (state == S_IDLE && req && !ack)
         cmd_q <= cmd;
   end

   //-----------------------------------------------------------------
   // decode through the view picked by the opcode
   //-----------------------------------------------------------------
   always_comb
   begin
      in_range = (cmd_q.tile.col < GRID_COLS) && (cmd_q.tile.row < GRID_ROWS);
      next_req = '0;
      if (cmd_q.tile.op == OP_BG)
      begin
         next_req.valid  = 1'b1;
         next_req.is_bg  = 1'b1;
         next_req.colour = cmd_q.bg.colour;
      end
      else
      begin
         next_req.valid  = in_range;     // out of range is acked but dropped
         next_req.addr   = tile_addr_t'(cmd_q.tile.row) * tile_addr_t'(GRID_COLS)
                           + tile_addr_t'(cmd_q.tile.col);
         next_req.colour = cmd_q.tile.colour;
      end
   end

   // handshake FSM, ack trails the state by one clock
   always_ff @(posedge clk_36MHz or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state <= S_IDLE;
         ack   <= 1'b0;
         store <= '0;
      end
      else
      begin
         store.valid <= 1'b0;              // strobe is a single cycle
         ack         <= (state == S_ACKD); // up 2 after accept, down 1 after req low
         case (state)
            S_IDLE:  if (req && !ack) state <= S_ISSUE;
            S_ISSUE:
            begin
               store <= next_req;
               state <= S_ACKD;
            end
            S_ACKD:  if (ack && !req) state <= S_IDLE;
            default: state <= S_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: tile_store.sv
//--------------------------------------------------------------------
// tile map and background register, written by the decoder and read
// by the video side through a one cycle registered port
//--------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tile_store
(
   input  wire                          clk_36MHz,
   input  wire                          arst_n,
   input  wire tile_cmd_pkg::store_req_t store,
   input  wire tile_cmd_pkg::tile_addr_t rd_addr,
   output video_timing_pkg::rgb_t       tile_colour,
   output video_timing_pkg::rgb_t       bg_colour
);
   import video_timing_pkg::*;
   import tile_cmd_pkg::*;

   rgb_t mem [TILE_COUNT];   // one colour per tile, row major

   //-----------------------------------------------------------------
   // write side
   //-----------------------------------------------------------------
   always_ff @(posedge clk_36MHz or negedge arst_n)
   begin
      if (!arst_n)
      begin
         // whole map comes up black
         for (int i = 0; i < TILE_COUNT; i++)
            mem[i] <= '0;
         bg_colour <= '0;
      end
      else if (store.valid)
      begin
         if (store.is_bg)
            bg_colour <= store.colour;       // background takes effect at once
         else
            mem[store.addr] <= store.colour; // decoder keeps addr below 300
      end
   end

   //-----------------------------------------------------------------
   // read side, one cycle latency to match the video pipeline
   //-----------------------------------------------------------------
   always_ff @(posedge clk_36MHz or negedge arst_n)
   begin
      if (!arst_n)
         tile_colour <= '0;
      else if (rd_addr < TILE_COUNT)
         tile_colour <= mem[rd_addr];
      else
         tile_colour <= '0;   // past the map, shows background
   end

endmodule

`default_nettype wire

// File: vga_controller.sv
//--------------------------------------------------------------------
// VGA timing, tile lookup and registered pixel output; fields of vga
// describe the counter position from two clocks earlier
//--------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module vga_controller
#(
   parameter int ACTIVE_H = video_timing_pkg::ACTIVE_H,
   parameter int ACTIVE_V = video_timing_pkg::ACTIVE_V,
   parameter int H_FP     = video_timing_pkg::H_FP,
   parameter int H_PULSE  = video_timing_pkg::H_PULSE,
   parameter int H_BP     = video_timing_pkg::H_BP,
   parameter int V_FP     = video_timing_pkg::V_FP,
   parameter int V_PULSE  = video_timing_pkg::V_PULSE,
   parameter int V_BP     = video_timing_pkg::V_BP
)
(
   input  wire                           clk_36MHz,
   input  wire                           arst_n,
   output tile_cmd_pkg::tile_addr_t      rd_addr,
   input  wire video_timing_pkg::rgb_t   tile_colour,
   input  wire video_timing_pkg::rgb_t   bg_colour,
   output video_timing_pkg::vga_out_t    vga
);
   import video_timing_pkg::*;
   import tile_cmd_pkg::*;

   localparam int H_BLANK = H_FP + H_PULSE + H_BP;   // 192 clocks before active
   localparam int V_BLANK = V_FP + V_PULSE + V_BP;   // 29 lines before active
   localparam int H_TOTAL = H_BLANK + ACTIVE_H;      // 832
   localparam int V_TOTAL = V_BLANK + ACTIVE_V;      // 509

   coord_t h_cnt;
   coord_t v_cnt;
   logic   hsync_c;
   logic   vsync_c;
   logic   active_c;
   coord_t x_c;
   coord_t y_c;

   // stage one, aligned with the store read
   logic   hsync_s1;
   logic   vsync_s1;
   logic   active_s1;
   coord_t x_s1;
   coord_t y_s1;
   rgb_t   pix_colour;

   //-----------------------------------------------------------------
   // line and frame counters
   //-----------------------------------------------------------------
   always_ff @(posedge clk_36MHz or negedge arst_n)
   begin
      if (!arst_n)
      begin
         h_cnt <= '0;
         v_cnt <= '0;
      end
      else if (h_cnt < coord_t'(H_TOTAL - 1))
         h_cnt <= h_cnt + 1'b1;
      else
      begin
         h_cnt <= '0;                                 // end of line
         if (v_cnt < coord_t'(V_TOTAL - 1))
            v_cnt <= v_cnt + 1'b1;
         else
            v_cnt <= '0;                              // end of frame
      end
   end

   // sync pulses sit right after the front porch, active low
   assign hsync_c  = !((h_cnt >= coord_t'(H_FP)) && (h_cnt < coord_t'(H_FP + H_PULSE)));
   assign vsync_c  = !((v_cnt >= coord_t'(V_FP)) && (v_cnt < coord_t'(V_FP + V_PULSE)));
   assign active_c = (h_cnt >= coord_t'(H_BLANK)) && (v_cnt >= coord_t'(V_BLANK));

   // active coordinates, 0 in blanking so the lookup lands on tile 0
   assign x_c = active_c ? h_cnt - coord_t'(H_BLANK) : '0;
   assign y_c = active_c ? v_cnt - coord_t'(V_BLANK) : '0;

   // tile index = (y / 32) * 20 + x / 32
   assign rd_addr = tile_addr_t'(y_c >> TILE_SHIFT) * tile_addr_t'(GRID_COLS)
                    + tile_addr_t'(x_c >> TILE_SHIFT);

   //-----------------------------------------------------------------
   // stage one, position and flags wait for the store read
   //-----------------------------------------------------------------
   always_ff @(posedge clk_36MHz or negedge arst_n)
   begin
      if (!arst_n)
      begin
         hsync_s1  <= 1'b1;
         vsync_s1  <= 1'b1;
         active_s1 <= 1'b0;
         x_s1      <= '0;
         y_s1      <= '0;
      end
      else
      begin
         hsync_s1  <= hsync_c;
         vsync_s1  <= vsync_c;
         active_s1 <= active_c;
         x_s1      <= x_c;
         y_s1      <= y_c;
      end
   end

   // tile 0 means transparent, show background
   assign pix_colour = !active_s1           ? '0 :
                       (tile_colour != '0) ? tile_colour : bg_colour;

   // stage two, output register
   always_ff @(posedge clk_36MHz or negedge arst_n)
   begin
      if (!arst_n)
      begin
         vga.hsync  <= 1'b1;
         vga.vsync  <= 1'b1;
         vga.colour <= '0;
         vga.x      <= '0;
         vga.y      <= '0;
      end
      else
      begin
         vga.hsync  <= hsync_s1;
         vga.vsync  <= vsync_s1;
         vga.colour <= pix_colour;
         vga.x      <= x_s1;    // already zeroed outside active
         vga.y      <= y_s1;
      end
   end

endmodule

`default_nettype wire

// File: tile_display_top.sv
//--------------------------------------------------------------------
// tiled colour display, host command port in and VGA out; timing is
// set here and handed down to the video block
//--------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tile_display_top
#(
   parameter int ACTIVE_H = video_timing_pkg::ACTIVE_H,
   parameter int ACTIVE_V = video_timing_pkg::ACTIVE_V,
   parameter int H_FP     = video_timing_pkg::H_FP,
   parameter int H_PULSE  = video_timing_pkg::H_PULSE,
   parameter int H_BP     = video_timing_pkg::H_BP,
   parameter int V_FP     = video_timing_pkg::V_FP,
   parameter int V_PULSE  = video_timing_pkg::V_PULSE,
   parameter int V_BP     = video_timing_pkg::V_BP
)
(
   input  wire                             clk_36MHz,
   input  wire                             arst_n,
   input  wire                             req,
   input  wire tile_cmd_pkg::cmd_u         cmd,
   output wire                             ack,
   output wire video_timing_pkg::vga_out_t vga
);
   import video_timing_pkg::*;
   import tile_cmd_pkg::*;

   wire store_req_t store;         // decoder write strobe
   wire tile_addr_t rd_addr;       // video lookup address
   wire rgb_t       tile_colour;
   wire rgb_t       bg_colour;

   //-----------------------------------------------------------------
   // decode, execute, result
   //-----------------------------------------------------------------
   cmd_decoder u_decoder
   (
      .clk_36MHz (clk_36MHz),
      .arst_n    (arst_n),
      .req       (req),
      .cmd       (cmd),
      .ack       (ack),
      .store     (store)
   );

   tile_store u_store
   (
      .clk_36MHz   (clk_36MHz),
      .arst_n      (arst_n),
      .store       (store),
      .rd_addr     (rd_addr),
      .tile_colour (tile_colour),
      .bg_colour   (bg_colour)
   );

   vga_controller
   #(
      .ACTIVE_H (ACTIVE_H),
      .ACTIVE_V (ACTIVE_V),
      .H_FP     (H_FP),
      .H_PULSE  (H_PULSE),
      .H_BP     (H_BP),
      .V_FP     (V_FP),
      .V_PULSE  (V_PULSE),
      .V_BP     (V_BP)
   )
   u_vga
   (
      .clk_36MHz   (clk_36MHz),
      .arst_n      (arst_n),
      .rd_addr     (rd_addr),
      .tile_colour (tile_colour),
      .bg_colour   (bg_colour),
      .vga         (vga)
   );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
//--------------------------------------------------------------------
// testbench clock source, 8 ns period, and reset held for 16 cycles
//--------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen
(
   output logic clk_36MHz,
   output logic arst_n
);

   initial
   begin
      clk_36MHz = 1'b0;
      forever
         #4 clk_36MHz = ~clk_36MHz;   // 8 ns period
   end

   // reset low for 16 rising edges, released on a falling edge
   initial
   begin
      arst_n = 1'b0;
      repeat (16)
         @(posedge clk_36MHz);
      @(negedge clk_36MHz);
      arst_n = 1'b1;
   end

endmodule

`default_nettype wire

// File: tile_display_tb.sv
//--------------------------------------------------------------------
// testbench for the tiled display, drives host commands, keeps a tile
// map model and checks handshake, sync timing, blanking and pixels
//--------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tile_display_tb;
   import video_timing_pkg::*;
   import tile_cmd_pkg::*;

   localparam int H_START = H_FP + H_PULSE + H_BP;   // first active clock in a line
   localparam int V_START = V_FP + V_PULSE + V_BP;   // first active line
   localparam int H_TOTAL = H_START + ACTIVE_H;      // 832
   localparam int V_TOTAL = V_START + ACTIVE_V;      // 509
   localparam int FRAME   = H_TOTAL * V_TOTAL;

   logic        clk_36MHz;
   logic        arst_n;
   logic        req;
   cmd_u        cmd;
   logic        ack;
   vga_out_t    vga;

   rgb_t        model_map [GRID_COLS * GRID_ROWS];   // expected tile colours
   rgb_t        model_bg;
   rgb_t        exp_c;
   logic [15:0] lfsr = 16'd5098;                     // random source seed
   string       cur_test;
   int          tests;
   int          failed;
   int          checks;
   int          errors;
   int          test_err;
   int          pix_count;
   int          h_pos;                               // counter model, output aligned
   int          v_pos;
   int          px;
   int          py;
   bit          h_lock;
   bit          v_lock;
   bit          prev_hs;
   bit          prev_vs;
   bit          timed_out;
   bit          chk_blank;
   bit          chk_pix;

   tb_clock_gen u_clk (.clk_36MHz(clk_36MHz), .arst_n(arst_n));

   tile_display_top UUT
   (
      .clk_36MHz (clk_36MHz),
      .arst_n    (arst_n),
      .req       (req),
      .cmd       (cmd),
      .ack       (ack),
      .vga       (vga)
   );

   //-----------------------------------------------------------------
   // helpers
   //-----------------------------------------------------------------
   // galois lfsr, one step per bit taken
   function automatic logic [15:0] take_bits(input int n);
      logic [15:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v    = {v[14:0], lfsr[0]};
         lfsr = lfsr[0] ? (lfsr >> 1) ^ 16'hB400 : lfsr >> 1;
      end
      return v;
   endfunction

   task automatic check_val(input string what, input int expected, input int actual);
      checks++;
      assert (expected == actual)
      else
      begin
         errors++;
         test_err++;
         $display("mismatch %s (%s): expected %0d, actual %0d",
                  cur_test, what, expected, actual);
      end
   endtask

   function automatic logic probe(input int sel);
      case (sel)
         0:       return ack;
         1:       return vga.hsync;
         default: return vga.vsync;
      endcase
   endfunction

   // counts falling edges until the signal reaches level
   task automatic wait_level(input int sel, input logic level, input int limit,
                             input string what, output int waited);
      waited = 0;
      while (!timed_out && probe(sel) !== level && waited < limit)
      begin
         @(negedge clk_36MHz);
         waited++;
      end
      if (!timed_out && probe(sel) !== level)
      begin
         timed_out = 1'b1;
         $display("timeout in %s: %s did not go to %0b within %0d cycles",
                  cur_test, what, level, limit);
      end
   endtask

   task automatic wait_fall(input int sel, input int limit, input string what);
      int w;
      wait_level(sel, 1'b1, limit, what, w);
      wait_level(sel, 1'b0, limit, what, w);
   endtask

   // one full four-phase transfer, model follows once ack is seen
   task automatic send_cmd(input cmd_u c, input int hold);
      int rise_n;
      int fall_n;
      @(negedge clk_36MHz);
      cmd = c;
      req = 1'b1;
      wait_level(0, 1'b1, 20, "ack", rise_n);
      if (timed_out)
         return;
      check_val("ack rise latency", 2, rise_n - 1);   // first wait edge is the sampling one
      if (c.tile.op == OP_BG)
         model_bg = c.bg.colour;
      else if (c.tile.col < GRID_COLS && c.tile.row < GRID_ROWS)
         model_map[c.tile.row * GRID_COLS + c.tile.col] = c.tile.colour;
      repeat (hold)
      begin
         @(negedge clk_36MHz);
         check_val("ack held", 1, ack);
      end
      req = 1'b0;
      wait_level(0, 1'b0, 20, "ack", fall_n);
      if (!timed_out)
         check_val("ack fall latency", 1, fall_n - 1);
   endtask

   // check blanking, and pixels too if asked, for one whole frame
   task automatic scan_frame(input bit pix);
      wait_fall(2, FRAME + 1000, "vsync");
      pix_count = 0;
      chk_blank <= 1'b1;
      chk_pix   <= pix;
      wait_fall(2, FRAME + 1000, "vsync");
      chk_blank <= 1'b0;
      chk_pix   <= 1'b0;
      if (pix && !timed_out)
         check_val("active pixels seen", ACTIVE_H * ACTIVE_V, pix_count);
   endtask

   task automatic begin_test(input string name);
      cur_test = name;
      test_err = 0;
      tests++;
   endtask

   task automatic end_test();
      if (test_err == 0 && !timed_out)
         $display("test %s: pass", cur_test);
      else
      begin
         failed++;
         $display("test %s: fail, %0d errors%s", cur_test, test_err,
                  timed_out ? ", timed out" : "");
      end
   endtask

   //-----------------------------------------------------------------
   // position tracker and per pixel checks
   //-----------------------------------------------------------------
   always @(negedge clk_36MHz)
   begin
      if (!arst_n)
      begin
         h_lock  = 1'b0;
         v_lock  = 1'b0;
         prev_hs = 1'b1;
         prev_vs = 1'b1;
      end
      else
      begin
         if (prev_hs && !vga.hsync)
         begin
            h_pos  = H_FP;   // hsync falls right after the front porch
            h_lock = 1'b1;
         end
         else
         begin
            h_pos = (h_pos == H_TOTAL - 1) ? 0 : h_pos + 1;
            if (h_pos == 0)
               v_pos = (v_pos == V_TOTAL - 1) ? 0 : v_pos + 1;
         end
         if (prev_vs && !vga.vsync)
         begin
            v_pos  = V_FP;
            v_lock = 1'b1;
         end
         prev_hs = vga.hsync;
         prev_vs = vga.vsync;
         if (h_lock && v_lock)
         begin
            if (h_pos < H_START || v_pos < V_START)
            begin
               if (chk_blank)
                  check_val("blank colour/x/y", 0, {vga.colour, vga.x, vga.y});
            end
            else if (chk_pix)
            begin
               px    = h_pos - H_START;
               py    = v_pos - V_START;
               exp_c = model_map[(py >> TILE_SHIFT) * GRID_COLS + (px >> TILE_SHIFT)];
               if (exp_c == '0)
                  exp_c = model_bg;   // zero tile shows the background
               check_val("pixel position", py * 1024 + px, vga.y * 1024 + vga.x);
               check_val("pixel colour", exp_c, vga.colour);
               pix_count++;
            end
         end
      end
   end

   //-----------------------------------------------------------------
   // test sequence
   //-----------------------------------------------------------------
   initial
   begin
      int          n;
      int          w1;
      int          w2;
      logic [15:0] r;
      cmd_u        c;
      req      = 1'b0;
      cmd      = '0;
      model_bg = '0;
      for (int i = 0; i < GRID_COLS * GRID_ROWS; i++)
         model_map[i] = '0;
      n = 0;
      while (arst_n !== 1'b1 && n < 100)
      begin
         @(negedge clk_36MHz);
         n++;
      end
      if (arst_n !== 1'b1)
      begin
         timed_out = 1'b1;
         $display("timeout: reset was never released");
      end

      begin_test("handshake");
      check_val("ack after reset", 0, ack);
      c             = '0;
      c.tile.op     = OP_TILE;
      c.tile.col    = 5'd3;
      c.tile.row    = 4'd2;
      c.tile.colour = 3'b101;
      if (!timed_out)
         send_cmd(c, 6);                 // req held well past ack
      c.tile.col = 5'd19;
      c.tile.row = 4'd14;
      if (!timed_out)
         send_cmd(c, 0);                 // bottom right corner, drop at once
      end_test();

      begin_test("horizontal");
      wait_fall(1, 2 * H_TOTAL, "hsync");
      for (int i = 0; i < 3 && !timed_out; i++)
      begin
         wait_level(1, 1'b1, H_TOTAL, "hsync", w1);
         wait_level(1, 1'b0, H_TOTAL, "hsync", w2);
         if (!timed_out)
         begin
            check_val("hsync low width", H_PULSE, w1);
            check_val("hsync period", H_TOTAL, w1 + w2);
         end
      end
      end_test();

      begin_test("vertical");
      wait_fall(2, FRAME + 1000, "vsync");
      wait_level(2, 1'b1, FRAME, "vsync", w1);
      wait_level(2, 1'b0, FRAME, "vsync", w2);
      if (!timed_out)
      begin
         check_val("vsync low width", V_PULSE * H_TOTAL, w1);
         check_val("vsync period", FRAME, w1 + w2);
      end
      end_test();

      begin_test("blanking");
      if (!timed_out)
         scan_frame(1'b0);
      end_test();

      begin_test("tiles");
      for (int i = 0; i < 40 && !timed_out; i++)
      begin
         c             = '0;
         c.tile.op     = OP_TILE;
         c.tile.col    = 5'(take_bits(5) % GRID_COLS);
         c.tile.row    = 4'(take_bits(4) % GRID_ROWS);
         r             = take_bits(3);
         c.tile.colour = r[2:0];
         if (i % 20 == 9)
            c.tile.col = 5'(take_bits(5) | 16'd20);   // col 20..31, may alias
         if (i % 20 == 19)
            c.tile.row = 4'd15;
         send_cmd(c, 0);
      end
      if (!timed_out)
         scan_frame(1'b1);
      end_test();

      begin_test("background");
      r = take_bits(3);
      if (r[2:0] == model_bg)
         r = ~r;                         // force a visible change
      c           = '0;
      c.bg.op     = OP_BG;
      c.bg.colour = r[2:0];
      if (!timed_out)
         send_cmd(c, 1);
      if (!timed_out)
         scan_frame(1'b1);
      end_test();

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests, failed, checks, errors);
      if (failed == 0 && errors == 0 && !timed_out)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
video_timing_pkg.sv
tile_cmd_pkg.sv
cmd_decoder.sv
tile_store.sv
vga_controller.sv
tile_display_top.sv
tb_clock_gen.sv
tile_display_tb.sv

// File: Makefile
VERILATOR  := verilator
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
TOP        := tile_display_tb
FILELIST   := all.f
PASS_MSG   := *** TEST PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

clean:
	rm -rf obj_dir
